/* flist.f */
bp_pkg.sv
local_history_table.sv
pattern_history_table.sv
branch_target_buffer.sv
fetch_redirect.sv
branch_predictor_top.sv
tb_branch_predictor_sva.sv
tb_branch_predictor.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_branch_predictor
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int BHT_ENTRIES = 128;
    localparam int HIST_BITS   = 7;
    localparam int BTB_SETS    = 32;
    localparam int BTB_WAYS    = 4;
    localparam int PHT_ENTRIES = 1 << HIST_BITS;
    localparam int TRAIN_LIMIT = 32;
    localparam logic [31:0] RAND_SEED = 32'h1d63;

    logic                      clock;
    logic                      reset;
    logic [XLEN-1:0]           pc;
    logic [WAYS-1:0]           is_branch;
    logic [WAYS-1:0]           is_valid;
    logic [WAYS-1:0][XLEN-1:0] update_pc;
    logic [WAYS-1:0]           update_taken;
    logic [WAYS-1:0][XLEN-1:0] update_target;
    logic [WAYS-1:0]           update_valid;
    logic [XLEN-1:0]           next_pc;
    logic [WAYS-1:0]           predictions;

    // Reference model of histories, counters and BTB ways
    logic [HIST_BITS-1:0] m_hist [BHT_ENTRIES];
    logic [1:0]           m_ctr [PHT_ENTRIES];
    logic [XLEN-1:0]      m_bpc [BTB_SETS][BTB_WAYS];
    logic [XLEN-1:0]      m_btgt [BTB_SETS][BTB_WAYS];
    logic                 m_bval [BTB_SETS][BTB_WAYS];

    int          error_count;
    int          tests_run;
    int          tests_clean;
    int          test_start_errors;
    logic [31:0] rand_init;

    branch_predictor_top #(
        .BHT_ENTRIES (BHT_ENTRIES),
        .HIST_BITS   (HIST_BITS),
        .BTB_SETS    (BTB_SETS),
        .BTB_WAYS    (BTB_WAYS)
    ) uut (
        .clock         (clock),
        .reset         (reset),
        .pc            (pc),
        .is_branch     (is_branch),
        .is_valid      (is_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .update_valid  (update_valid),
        .next_pc       (next_pc),
        .predictions   (predictions)
    );

    bind branch_predictor_top tb_branch_predictor_sva u_sva (
        .clock       (clock),
        .reset       (reset),
        .pc          (pc),
        .is_branch   (is_branch),
        .is_valid    (is_valid),
        .next_pc     (next_pc),
        .predictions (predictions)
    );

    always #5 clock = ~clock;

    // Index fields start above the byte offset of an instruction
    function automatic int hist_index(input logic [XLEN-1:0] addr);
        return int'((addr / XLEN'(INSN_BYTES)) % XLEN'(BHT_ENTRIES));
    endfunction

    function automatic int set_index(input logic [XLEN-1:0] addr);
        return int'((addr / XLEN'(INSN_BYTES)) % XLEN'(BTB_SETS));
    endfunction

    function automatic void reset_model();
        for (int e = 0; e < BHT_ENTRIES; e++) begin
            m_hist[e] = '0;
        end
        for (int e = 0; e < PHT_ENTRIES; e++) begin
            m_ctr[e] = 2'b01;
        end
        for (int s = 0; s < BTB_SETS; s++) begin
            for (int w = 0; w < BTB_WAYS; w++) begin
                m_bval[s][w] = 1'b0;
                m_bpc[s][w]  = '0;
                m_btgt[s][w] = '0;
            end
        end
    endfunction

    function automatic void predict_group(input logic [XLEN-1:0] lpc,
                                          input logic [WAYS-1:0] br,
                                          input logic [WAYS-1:0] vl,
                                          output logic [XLEN-1:0] exp_next,
                                          output logic [WAYS-1:0] exp_pred);
        logic [XLEN-1:0]      addr;
        logic [HIST_BITS-1:0] h;
        logic [XLEN-1:0]      tgt;
        int                   s;
        bit                   hit;
        bit                   found;
        exp_next = lpc + XLEN'(WAYS * INSN_BYTES);
        exp_pred = '0;
        found = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            addr = lpc + XLEN'(i * INSN_BYTES);
            h = m_hist[hist_index(addr)];
            s = set_index(addr);
            hit = 1'b0;
            tgt = '0;
            for (int w = 0; w < BTB_WAYS; w++) begin
                if (!hit && m_bval[s][w] && m_bpc[s][w] == addr) begin
                    hit = 1'b1;
                    tgt = m_btgt[s][w];
                end
            end
            if (!found && br[i] && vl[i] && m_ctr[h][1] && hit) begin
                found = 1'b1;
                exp_pred[i] = 1'b1;
                exp_next = tgt;
            end
        end
    endfunction

    function automatic void retire_updates(input logic [WAYS-1:0][XLEN-1:0] upc,
                                           input logic [WAYS-1:0] tk,
                                           input logic [WAYS-1:0][XLEN-1:0] tgt,
                                           input logic [WAYS-1:0] uv);
        logic [HIST_BITS-1:0] old_h [WAYS];
        logic [1:0]           old_c [WAYS];
        logic [1:0]           new_c [WAYS];
        logic [XLEN-1:0]      n_pc [WAYS][BTB_WAYS];
        logic [XLEN-1:0]      n_tgt [WAYS][BTB_WAYS];
        logic                 n_val [WAYS][BTB_WAYS];
        int                   s [WAYS];
        int                   pos;
        // Every slot computes from the state before the edge
        for (int i = 0; i < WAYS; i++) begin
            old_h[i] = m_hist[hist_index(upc[i])];
            old_c[i] = m_ctr[old_h[i]];
            new_c[i] = tk[i] ? ((old_c[i] == 2'd3) ? 2'd3 : old_c[i] + 2'd1)
                             : ((old_c[i] == 2'd0) ? 2'd0 : old_c[i] - 2'd1);
            s[i] = set_index(upc[i]);
            pos = BTB_WAYS - 1;
            for (int w = BTB_WAYS - 1; w >= 0; w--) begin
                if (m_bval[s[i]][w] && m_bpc[s[i]][w] == upc[i]) begin
                    pos = w;
                end
            end
            for (int w = 0; w < BTB_WAYS; w++) begin
                if (w == 0) begin
                    n_pc[i][w]  = upc[i];
                    n_tgt[i][w] = tgt[i];
                    n_val[i][w] = 1'b1;
                end else if (w <= pos) begin
                    n_pc[i][w]  = m_bpc[s[i]][w-1];
                    n_tgt[i][w] = m_btgt[s[i]][w-1];
                    n_val[i][w] = m_bval[s[i]][w-1];
                end else begin
                    n_pc[i][w]  = m_bpc[s[i]][w];
                    n_tgt[i][w] = m_btgt[s[i]][w];
                    n_val[i][w] = m_bval[s[i]][w];
                end
            end
        end
        // Higher slot applied last, so it wins a shared entry
        for (int i = 0; i < WAYS; i++) begin
            if (uv[i]) begin
                m_hist[hist_index(upc[i])] = {old_h[i][HIST_BITS-2:0], tk[i]};
                // A saturated counter is not written at all
                if (new_c[i] != old_c[i]) begin
                    m_ctr[old_h[i]] = new_c[i];
                end
                if (tk[i]) begin
                    for (int w = 0; w < BTB_WAYS; w++) begin
                        m_bpc[s[i]][w]  = n_pc[i][w];
                        m_btgt[s[i]][w] = n_tgt[i][w];
                        m_bval[s[i]][w] = n_val[i][w];
                    end
                end
            end
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        update_valid <= '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        reset_model();
    endtask

    // Lookup is checked mid-cycle and the update lands on the next edge
    task automatic run_cycle(input logic [XLEN-1:0] lpc, input logic [WAYS-1:0] br,
                             input logic [WAYS-1:0] vl, input logic [XLEN-1:0] upc0,
                             input logic [XLEN-1:0] upc1, input logic [WAYS-1:0] tk,
                             input logic [XLEN-1:0] tg0, input logic [XLEN-1:0] tg1,
                             input logic [WAYS-1:0] uv);
        logic [WAYS-1:0][XLEN-1:0] upc_v;
        logic [WAYS-1:0][XLEN-1:0] tgt_v;
        logic [XLEN-1:0]           exp_next;
        logic [WAYS-1:0]           exp_pred;
        upc_v[0] = upc0;
        upc_v[1] = upc1;
        tgt_v[0] = tg0;
        tgt_v[1] = tg1;
        @(posedge clock);
        pc <= lpc;
        is_branch <= br;
        is_valid <= vl;
        update_pc <= upc_v;
        update_taken <= tk;
        update_target <= tgt_v;
        update_valid <= uv;
        @(negedge clock);
        predict_group(lpc, br, vl, exp_next, exp_pred);
        check_value(32'(predictions), 32'(exp_pred), "predictions");
        check_value(next_pc, exp_next, "next_pc");
        retire_updates(upc_v, tk, tgt_v, uv);
    endtask

    task automatic lookup_group(input logic [XLEN-1:0] lpc, input logic [WAYS-1:0] br,
                                input logic [WAYS-1:0] vl);
        run_cycle(lpc, br, vl, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic commit_slot0(input logic [XLEN-1:0] upc, input logic tk,
                                input logic [XLEN-1:0] tgt);
        run_cycle(upc, '0, '0, upc, upc, {1'b0, tk}, tgt, tgt, 2'b01);
    endtask

    task automatic expect_slot0(input logic [XLEN-1:0] lpc, input logic taken,
                                input logic [XLEN-1:0] tgt);
        lookup_group(lpc, 2'b01, 2'b01);
        check_value(32'(predictions), {31'b0, taken}, "slot 0 prediction");
        check_value(next_pc, taken ? tgt : lpc + XLEN'(WAYS * INSN_BYTES), "slot 0 next_pc");
    endtask

    // Commit one branch until the slot 0 prediction for look_pc reaches want
    task automatic train_until(input logic [XLEN-1:0] commit_pc, input logic taken,
                               input logic [XLEN-1:0] target, input logic [XLEN-1:0] look_pc,
                               input logic want, output int commits);
        bit reached;
        reached = 1'b0;
        commits = 0;
        while (!reached && commits < TRAIN_LIMIT) begin
            commit_slot0(commit_pc, taken, target);
            lookup_group(look_pc, 2'b01, 2'b01);
            reached = (predictions[0] == want);
            commits++;
        end
        if (!reached) begin
            $display("Training with %h gave up after %0d commits at %0t ns",
                     commit_pc, commits, $time);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
        apply_reset();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            tests_clean++;
        end
        $display("%s: done, %0d errors", name, error_count - test_start_errors);
    endtask

    task automatic reset_state();
        logic [XLEN-1:0] pcs [4];
        pcs = '{32'h0000_0000, 32'h0000_0100, 32'h0000_1ffc, 32'hffff_fffc};
        start_test();
        for (int k = 0; k < 4; k++) begin
            lookup_group(pcs[k], 2'b11, 2'b11);
            check_value(32'(predictions), 32'h0, "predictions after reset");
            check_value(next_pc, pcs[k] + XLEN'(WAYS * INSN_BYTES), "next_pc after reset");
        end
        finish_test("reset_state");
    endtask

    task automatic taken_training();
        int n;
        start_test();
        train_until(32'h0000_1040, 1'b1, 32'h0000_8000, 32'h0000_1040, 1'b1, n);
        // All-ones history takes HIST_BITS commits and one more lifts its counter to 2
        check_value(32'(n), 32'(HIST_BITS + 1), "commits before first taken prediction");
        check_value(next_pc, 32'h0000_8000, "trained target");
        finish_test("taken_training");
    endtask

    task automatic not_taken_training();
        int n;
        start_test();
        train_until(32'h0000_1040, 1'b1, 32'h0000_8000, 32'h0000_1040, 1'b1, n);
        train_until(32'h0000_1040, 1'b0, 32'h0000_8000, 32'h0000_1040, 1'b0, n);
        check_value(next_pc, 32'h0000_1048, "fall-through after not-taken");
        // 0x1240 shares the history entry and the BTB set but has its own tag
        train_until(32'h0000_1240, 1'b1, 32'h0000_9000, 32'h0000_1040, 1'b1, n);
        check_value(next_pc, 32'h0000_8000, "kept target after retraining");
        finish_test("not_taken_training");
    endtask

    task automatic btb_replacement();
        logic [XLEN-1:0] bpc [BTB_WAYS+2];
        logic [XLEN-1:0] btg [BTB_WAYS+2];
        int              n;
        start_test();
        // Stride of one full set range keeps every PC in the same set
        for (int k = 0; k < BTB_WAYS + 2; k++) begin
            bpc[k] = 32'h0000_2010 + XLEN'(k * BTB_SETS * INSN_BYTES);
            btg[k] = 32'h0000_a000 + XLEN'(k * 16);
        end
        for (int k = 0; k <= BTB_WAYS; k++) begin
            train_until(bpc[k], 1'b1, btg[k], bpc[k], 1'b1, n);
        end
        expect_slot0(bpc[0], 1'b0, btg[0]);
        for (int k = 1; k <= BTB_WAYS; k++) begin
            expect_slot0(bpc[k], 1'b1, btg[k]);
        end
        commit_slot0(bpc[1], 1'b1, btg[1]);
        commit_slot0(bpc[BTB_WAYS+1], 1'b1, btg[BTB_WAYS+1]);
        expect_slot0(bpc[1], 1'b1, btg[1]);
        expect_slot0(bpc[2], 1'b0, btg[2]);
        finish_test("btb_replacement");
    endtask

    task automatic slot_priority();
        int n;
        start_test();
        train_until(32'h0000_3000, 1'b1, 32'h0000_b000, 32'h0000_3000, 1'b1, n);
        train_until(32'h0000_3004, 1'b1, 32'h0000_b100, 32'h0000_3004, 1'b1, n);
        lookup_group(32'h0000_3000, 2'b11, 2'b11);
        check_value(32'(predictions), 32'h1, "both slots taken, predictions");
        check_value(next_pc, 32'h0000_b000, "both slots taken, next_pc");
        lookup_group(32'h0000_3000, 2'b10, 2'b11);
        check_value(32'(predictions), 32'h2, "slot 0 not a branch, predictions");
        check_value(next_pc, 32'h0000_b100, "slot 0 not a branch, next_pc");
        lookup_group(32'h0000_3000, 2'b11, 2'b10);
        check_value(32'(predictions), 32'h2, "slot 0 invalid, predictions");
        check_value(next_pc, 32'h0000_b100, "slot 0 invalid, next_pc");
        finish_test("slot_priority");
    endtask

    task automatic random_mix();
        logic [XLEN-1:0] pool [8];
        logic [31:0]     r;
        logic [XLEN-1:0] upc0;
        logic [XLEN-1:0] upc1;
        pool = '{32'h4000, 32'h4004, 32'h4008, 32'h4080, 32'h4084, 32'h4200, 32'h4204, 32'h41fc};
        start_test();
        for (int n = 0; n < 400; n++) begin
            r = $urandom;
            upc0 = pool[r[13:11]];
            // A quarter of the cycles send both update slots to one branch
            upc1 = (r[15:14] == 2'b00) ? upc0 : pool[r[18:16]];
            run_cycle(pool[r[2:0]], r[4:3], r[6:5], upc0, upc1, r[10:9] | r[28:27],
                      {26'h0, r[22:19], 2'b00} + 32'hc000,
                      {26'h0, r[26:23], 2'b00} + 32'hc000, r[8:7]);
        end
        finish_test("random_mix");
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        pc = '0;
        is_branch = '0;
        is_valid = '0;
        update_pc = '0;
        update_taken = '0;
        update_target = '0;
        update_valid = '0;
        error_count = 0;
        tests_run = 0;
        tests_clean = 0;
        test_start_errors = 0;
        rand_init = $urandom(RAND_SEED);
        reset_model();

        reset_state();
        taken_training();
        not_taken_training();
        btb_replacement();
        slot_priority();
        random_mix();

        $display("Summary: %0d of %0d tests clean, %0d errors", tests_clean, tests_run,
                 error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb_branch_predictor_sva.sv */
`timescale 1ns/1ps

module tb_branch_predictor_sva (
    input logic                      clock,
    input logic                      reset,
    input logic [bp_pkg::XLEN-1:0]   pc,
    input logic [bp_pkg::WAYS-1:0]   is_branch,
    input logic [bp_pkg::WAYS-1:0]   is_valid,
    input logic [bp_pkg::XLEN-1:0]   next_pc,
    input logic [bp_pkg::WAYS-1:0]   predictions
);

    import bp_pkg::*;

    // Only the first taken slot of a group may redirect
    single_redirect: assert property (
        @(posedge clock) disable iff (reset) $onehot0(predictions)
    ) else $error("more than one prediction bit set: %b", predictions);

    // A slot needs a valid branch before it can be predicted
    gated_slots: assert property (
        @(posedge clock) disable iff (reset) (predictions & ~(is_branch & is_valid)) == '0
    ) else $error("prediction on a slot that is not a valid branch: %b", predictions);

    fall_through: assert property (
        @(posedge clock) disable iff (reset)
        predictions == '0 |-> next_pc == pc + XLEN'(FETCH_STRIDE)
    ) else $error("no prediction but next_pc %h is not the fall-through of %h", next_pc, pc);

endmodule

/* branch_predictor_top.sv */
`timescale 1ns/1ps

module branch_predictor_top #(
    parameter int BHT_ENTRIES = 128,
    parameter int HIST_BITS   = 7,
    parameter int BTB_SETS    = 32,
    parameter int BTB_WAYS    = 4
) (
    input  logic                                      clock,
    input  logic                                      reset,

    // Fetch group lookup
    input  logic [bp_pkg::XLEN-1:0]                   pc,
    input  logic [bp_pkg::WAYS-1:0]                   is_branch,
    input  logic [bp_pkg::WAYS-1:0]                   is_valid,

    // Committed branch outcomes
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] update_pc,
    input  logic [bp_pkg::WAYS-1:0]                   update_taken,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] update_target,
    input  logic [bp_pkg::WAYS-1:0]                   update_valid,

    output logic [bp_pkg::XLEN-1:0]                   next_pc,
    output logic [bp_pkg::WAYS-1:0]                   predictions
);

    import bp_pkg::*;

    logic [WAYS-1:0][HIST_BITS-1:0] fetch_history;
    logic [WAYS-1:0][HIST_BITS-1:0] update_history;
    logic [WAYS-1:0]                taken_hint;
    logic [WAYS-1:0]                btb_hit;
    logic [WAYS-1:0][XLEN-1:0]      btb_target;

    local_history_table #(
        .BHT_ENTRIES (BHT_ENTRIES),
        .HIST_BITS   (HIST_BITS)
    ) u_lht (
        .clock          (clock),
        .reset          (reset),
        .pc             (pc),
        .update_pc      (update_pc),
        .update_taken   (update_taken),
        .update_valid   (update_valid),
        .fetch_history  (fetch_history),
        .update_history (update_history)
    );

    pattern_history_table #(
        .HIST_BITS (HIST_BITS)
    ) u_pht (
        .clock          (clock),
        .reset          (reset),
        .fetch_history  (fetch_history),
        .update_history (update_history),
        .update_taken   (update_taken),
        .update_valid   (update_valid),
        .taken_hint     (taken_hint)
    );

    branch_target_buffer #(
        .BTB_SETS (BTB_SETS),
        .BTB_WAYS (BTB_WAYS)
    ) u_btb (
        .clock         (clock),
        .reset         (reset),
        .pc            (pc),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .update_valid  (update_valid),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target)
    );

    fetch_redirect u_redirect (
        .pc          (pc),
        .is_branch   (is_branch),
        .is_valid    (is_valid),
        .taken_hint  (taken_hint),
        .btb_hit     (btb_hit),
        .btb_target  (btb_target),
        .next_pc     (next_pc),
        .predictions (predictions)
    );

endmodule

/* fetch_redirect.sv */
`timescale 1ns/1ps

module fetch_redirect (
    input  logic [bp_pkg::XLEN-1:0]                   pc,
    input  logic [bp_pkg::WAYS-1:0]                   is_branch,
    input  logic [bp_pkg::WAYS-1:0]                   is_valid,
    input  logic [bp_pkg::WAYS-1:0]                   taken_hint,
    input  logic [bp_pkg::WAYS-1:0]                   btb_hit,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] btb_target,
    output logic [bp_pkg::XLEN-1:0]                   next_pc,
    output logic [bp_pkg::WAYS-1:0]                   predictions
);

    import bp_pkg::*;

    // Needs a live branch, a taken counter and a known target
    logic [WAYS-1:0] slot_taken;

    assign slot_taken = is_valid & is_branch & taken_hint & btb_hit;

    // Walk from the top slot down so the lowest taken slot is last to assign
    always_comb begin
        next_pc     = pc + XLEN'(FETCH_STRIDE);
        predictions = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (slot_taken[i]) begin
                next_pc        = btb_target[i];
                predictions    = '0;
                predictions[i] = 1'b1;
            end
        end
    end

endmodule

/* branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int BTB_SETS = 32,
    parameter int BTB_WAYS = 4
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [bp_pkg::XLEN-1:0]                   pc,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] update_pc,
    input  logic [bp_pkg::WAYS-1:0]                   update_taken,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] update_target,
    input  logic [bp_pkg::WAYS-1:0]                   update_valid,
    output logic [bp_pkg::WAYS-1:0]                   btb_hit,
    output logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0] btb_target
);

    import bp_pkg::*;

    localparam int SET_BITS = $clog2(BTB_SETS);
    localparam int WAY_BITS = (BTB_WAYS > 1) ? $clog2(BTB_WAYS) : 1;

    // Way 0 holds the most recently inserted branch of each set
    logic [BTB_WAYS-1:0][XLEN-1:0] btb_pc [BTB_SETS];
    logic [BTB_WAYS-1:0][XLEN-1:0] btb_tgt [BTB_SETS];
    logic [BTB_WAYS-1:0]           btb_valid [BTB_SETS];

    logic [SET_BITS-1:0] fetch_set [WAYS];
    logic [XLEN-1:0]     fetch_tag [WAYS];

    logic [SET_BITS-1:0]           upd_set [WAYS];
    logic [WAY_BITS-1:0]           upd_pos [WAYS];
    logic                          upd_write [WAYS];
    logic [BTB_WAYS-1:0][XLEN-1:0] new_pc [WAYS];
    logic [BTB_WAYS-1:0][XLEN-1:0] new_tgt [WAYS];
    logic [BTB_WAYS-1:0]           new_valid [WAYS];

    // Lowest matching way wins the lookup
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            fetch_set[i]  = pc[SET_BITS+INSN_OFFSET-1:INSN_OFFSET] + SET_BITS'(i);
            fetch_tag[i]  = pc + XLEN'(i * INSN_BYTES);
            btb_hit[i]    = 1'b0;
            btb_target[i] = '0;
            for (int j = BTB_WAYS - 1; j >= 0; j--) begin
                if (btb_valid[fetch_set[i]][j] && btb_pc[fetch_set[i]][j] == fetch_tag[i]) begin
                    btb_hit[i]    = 1'b1;
                    btb_target[i] = btb_tgt[fetch_set[i]][j];
                end
            end
        end
    end

    // Next contents of the set each update slot touches
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            upd_set[i]   = update_pc[i][SET_BITS+INSN_OFFSET-1:INSN_OFFSET];
            upd_write[i] = update_valid[i] && update_taken[i];

            // Miss falls back to the oldest way
            upd_pos[i] = WAY_BITS'(BTB_WAYS - 1);
            for (int j = BTB_WAYS - 1; j >= 0; j--) begin
                if (btb_valid[upd_set[i]][j] && btb_pc[upd_set[i]][j] == update_pc[i]) begin
                    upd_pos[i] = WAY_BITS'(j);
                end
            end

            new_pc[i]    = btb_pc[upd_set[i]];
            new_tgt[i]   = btb_tgt[upd_set[i]];
            new_valid[i] = btb_valid[upd_set[i]];

            // Slide the younger ways down to close the gap
            for (int j = 1; j < BTB_WAYS; j++) begin
                if (WAY_BITS'(j) <= upd_pos[i]) begin
                    new_pc[i][j]    = btb_pc[upd_set[i]][j-1];
                    new_tgt[i][j]   = btb_tgt[upd_set[i]][j-1];
                    new_valid[i][j] = btb_valid[upd_set[i]][j-1];
                end
            end

            new_pc[i][0]    = update_pc[i];
            new_tgt[i][0]   = update_target[i];
            new_valid[i][0] = 1'b1;
        end
    end

    // Whole set is rewritten, so the higher slot wins on a shared set
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                btb_valid[s] <= '0;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (upd_write[i]) begin
                    btb_valid[upd_set[i]] <= new_valid[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < WAYS; i++) begin
            if (upd_write[i]) begin
                btb_pc[upd_set[i]]  <= new_pc[i];
                btb_tgt[upd_set[i]] <= new_tgt[i];
            end
        end
    end

endmodule

/* pattern_history_table.sv */
`timescale 1ns/1ps

module pattern_history_table #(
    parameter int HIST_BITS = 7
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [bp_pkg::WAYS-1:0][HIST_BITS-1:0]   fetch_history,
    input  logic [bp_pkg::WAYS-1:0][HIST_BITS-1:0]   update_history,
    input  logic [bp_pkg::WAYS-1:0]                  update_taken,
    input  logic [bp_pkg::WAYS-1:0]                  update_valid,
    output logic [bp_pkg::WAYS-1:0]                  taken_hint
);

    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << HIST_BITS;

    // Two-bit saturating counters whose upper bit means taken
    logic [1:0] ctr [PHT_ENTRIES];

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            taken_hint[i] = ctr[fetch_history[i]][1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < PHT_ENTRIES; e++) begin
                ctr[e] <= CTR_WEAK_NT;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (update_valid[i]) begin
                    if (update_taken[i]) begin
                        if (ctr[update_history[i]] != CTR_STRONG_T) begin
                            ctr[update_history[i]] <= ctr[update_history[i]] + 2'd1;
                        end
                    end else begin
                        if (ctr[update_history[i]] != CTR_STRONG_NT) begin
                            ctr[update_history[i]] <= ctr[update_history[i]] - 2'd1;
                        end
                    end
                end
            end
        end
    end

endmodule

/* local_history_table.sv */
`timescale 1ns/1ps

module local_history_table #(
    parameter int BHT_ENTRIES = 128,
    parameter int HIST_BITS   = 7
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic [bp_pkg::XLEN-1:0]                       pc,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::XLEN-1:0]     update_pc,
    input  logic [bp_pkg::WAYS-1:0]                       update_taken,
    input  logic [bp_pkg::WAYS-1:0]                       update_valid,
    output logic [bp_pkg::WAYS-1:0][HIST_BITS-1:0]        fetch_history,
    output logic [bp_pkg::WAYS-1:0][HIST_BITS-1:0]        update_history
);

    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(BHT_ENTRIES);

    // One outcome shift register per branch entry
    logic [HIST_BITS-1:0] hist [BHT_ENTRIES];

    logic [IDX_BITS-1:0] base_idx;
    logic [IDX_BITS-1:0] fetch_idx [WAYS];
    logic [IDX_BITS-1:0] upd_idx [WAYS];

    assign base_idx = pc[IDX_BITS+INSN_OFFSET-1:INSN_OFFSET];

    // Consecutive slots use consecutive entries, wrapping at the table end
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            fetch_idx[i] = base_idx + IDX_BITS'(i);
            upd_idx[i]   = update_pc[i][IDX_BITS+INSN_OFFSET-1:INSN_OFFSET];
        end
    end

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            fetch_history[i] = hist[fetch_idx[i]];
            // Pre-update value so the counter trains on the pattern it predicted with
            update_history[i] = hist[upd_idx[i]];
        end
    end

    // Later slots come last in the loop and win on a shared entry
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < BHT_ENTRIES; e++) begin
                hist[e] <= '0;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (update_valid[i]) begin
                    hist[upd_idx[i]] <= {hist[upd_idx[i]][HIST_BITS-2:0], update_taken[i]};
                end
            end
        end
    end

endmodule

/* bp_pkg.sv */
package bp_pkg;

    // Address width of the core
    localparam int XLEN = 32;

    // Fetch and commit width in instructions
    localparam int WAYS = 2;

    // Size of one instruction in bytes
    localparam int INSN_BYTES = 4;

    // Low PC bits that only select a byte inside an instruction
    localparam int INSN_OFFSET = $clog2(INSN_BYTES);

    // Bytes covered by one whole fetch group
    localparam int FETCH_STRIDE = WAYS * INSN_BYTES;

    // Two-bit counter encodings used by the pattern table
    localparam logic [1:0] CTR_STRONG_NT = 2'b00;
    localparam logic [1:0] CTR_WEAK_NT   = 2'b01;
    localparam logic [1:0] CTR_STRONG_T  = 2'b11;

endpackage
